// File: Bender.yml
package:
  name: br_slice

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/br_pkg.sv
      - hw/br_issue_queue.sv
      - hw/fu_br.sv
      - hw/btb.sv
      - hw/br_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_br_top.sv

// File: bench/tb_br_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "br_defs.svh"

module tb_br_top
    import br_pkg::*;
();

    localparam int NMAIN   = 30;           // jumps, branches and mispredictions
    localparam int NTOTAL  = NMAIN + 3;    // two flush victims and one op after the flush
    localparam int TIMEOUT = 40;

    logic           clk;
    logic           rst;
    logic           flush;
    logic           issue_valid;
    issue_t         issue;
    logic           issue_ready;
    logic           valid;
    logic           busy;
    result_t        result;
    redirect_t      redirect;
    logic   [31:0]  lookup_pc;
    logic           pred_hit;
    logic   [31:0]  pred_target;

    issue_t         stim    [NTOTAL];
    result_t        exp_res [NTOTAL];
    redirect_t      exp_rdr [NTOTAL];
    logic   [31:0]  lfsr_state;
    logic   [`BTB_DEPTH-1:0] mdl_valid;
    logic   [21:0]  mdl_tag    [`BTB_DEPTH];
    logic   [31:0]  mdl_target [`BTB_DEPTH];
    int             errors;

    br_f3_e         f3_list   [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
    logic   [31:0]  edge_rs1  [3] = '{32'h8000_0000, 32'h8000_0000, 32'h0000_0000};
    logic   [31:0]  edge_rs2  [3] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};

    br_top br_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_word();
        logic [31:0] w;
        for (int b = 0; b < 32; b++) w[b] = lfsr_bit();
        return w;
    endfunction

    function automatic logic [31:0] pc_of(int n);
        return 32'h1000 + 32'(4 * n);
    endfunction

    function automatic issue_t make_op(br_op_e opc, br_f3_e f3, int n, logic [31:0] imm,
                                       logic bp, logic [31:0] bp_addr,
                                       logic [31:0] rs1, logic [31:0] rs2);
        issue_t op;
        op = '0;
        op.info.opcode  = opc;
        op.info.funct3  = f3;
        op.info.tag     = n[`BR_TAG_BITS-1:0];
        op.info.pc      = pc_of(n);
        // formats not in use carry other offsets so a wrong pick moves the target
        op.info.i_imm   = (opc == op_b_jalr) ? imm : imm + 32'h80;
        op.info.b_imm   = (opc == op_b_br)   ? imm : imm + 32'h100;
        op.info.j_imm   = (opc == op_b_jal)  ? imm : imm + 32'h200;
        op.info.bp      = bp;
        op.info.bp_addr = bp_addr;
        op.rs1_v        = rs1;
        op.rs2_v        = rs2;
        return op;
    endfunction

    // signed order is the unsigned order with both sign bits flipped
    function automatic logic taken_rule(issue_t op);
        logic [31:0] a_s;
        logic [31:0] b_s;
        a_s = op.rs1_v ^ 32'h8000_0000;
        b_s = op.rs2_v ^ 32'h8000_0000;
        if (op.info.opcode != op_b_br) return 1'b1;
        case (op.info.funct3)
            f3_beq:  return op.rs1_v == op.rs2_v;
            f3_bne:  return op.rs1_v != op.rs2_v;
            f3_blt:  return a_s < b_s;
            f3_bge:  return !(a_s < b_s);
            f3_bltu: return op.rs1_v < op.rs2_v;
            default: return !(op.rs1_v < op.rs2_v);
        endcase
    endfunction

    function automatic logic [31:0] target_rule(issue_t op);
        logic [31:0] sum;
        sum = op.rs1_v + op.info.i_imm;
        sum[0] = 1'b0;
        if (op.info.opcode == op_b_jal) return op.info.pc + op.info.j_imm;
        if (op.info.opcode == op_b_jalr) return sum;
        return op.info.pc + op.info.b_imm;
    endfunction

    function automatic redirect_t redirect_rule(issue_t op);
        redirect_t r;
        r = '0;
        if (op.info.bp && !taken_rule(op)) begin
            r = '{1'b1, op.info.pc + 32'd4};
        end else if (taken_rule(op) && !(op.info.bp && op.info.bp_addr == target_rule(op))) begin
            r = '{1'b1, target_rule(op)};
        end
        return r;
    endfunction

    task automatic abort_run();
        errors++;
        $display("Done: errors found");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic stop_with_error(string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    task automatic check_result(result_t got, result_t exp);
        if (got.tag !== exp.tag) report_mismatch("result.tag", 64'(got.tag), 64'(exp.tag));
        if (got.rd_v !== exp.rd_v) report_mismatch("result.rd_v", 64'(got.rd_v), 64'(exp.rd_v));
    endtask

    task automatic check_redirect(redirect_t got, redirect_t exp);
        if (got.pc_select !== exp.pc_select)
            report_mismatch("redirect.pc_select", 64'(got.pc_select), 64'(exp.pc_select));
        if (exp.pc_select && got.pc_branch !== exp.pc_branch)
            report_mismatch("redirect.pc_branch", 64'(got.pc_branch), 64'(exp.pc_branch));
    endtask

    task automatic check_btb(logic [31:0] pc);
        logic exp_hit;
        exp_hit = mdl_valid[pc[9:2]] && (mdl_tag[pc[9:2]] == pc[31:10]);
        lookup_pc = pc;
        #1;
        if (pred_hit !== exp_hit) report_mismatch("pred_hit", 64'(pred_hit), 64'(exp_hit));
        if (exp_hit && pred_target !== mdl_target[pc[9:2]])
            report_mismatch("pred_target", 64'(pred_target), 64'(mdl_target[pc[9:2]]));
    endtask

    // the pc with bit 10 flipped shares the index but not the tag
    task automatic check_aliases(int first, int count);
        for (int i = first; i < first + count; i++) begin
            check_btb(stim[i].info.pc ^ 32'h400);
            @(negedge clk);
        end
    endtask

    // called at a falling edge, returns at the falling edge after the push
    task automatic push_op(issue_t op);
        int waited;
        waited = 0;
        issue_valid = 1'b1;
        issue = op;
        while (!issue_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) stop_with_error("issue_ready stayed low too long");
        end
        @(negedge clk);
    endtask

    task automatic collect_results(int first, int count);
        int got;
        int waited;
        int pend;
        got = 0;
        waited = 0;
        pend = -1;
        while (got < count || pend >= 0) begin
            @(negedge clk);
            if (pend >= 0) begin
                check_btb(stim[pend].info.pc);
                pend = -1;
            end
            if (valid) begin
                if (got >= count) stop_with_error("valid raised with no operation pending");
                if (busy !== 1'b1) report_mismatch("busy", 64'(busy), 64'h1);
                check_result(result, exp_res[first + got]);
                check_redirect(redirect, exp_rdr[first + got]);
                if (taken_rule(stim[first + got])) begin
                    mdl_valid[stim[first + got].info.pc[9:2]]  = 1'b1;
                    mdl_tag[stim[first + got].info.pc[9:2]]    = stim[first + got].info.pc[31:10];
                    mdl_target[stim[first + got].info.pc[9:2]] = target_rule(stim[first + got]);
                end
                pend = first + got;
                got++;
                waited = 0;
            end else if (got < count) begin
                waited++;
                if (waited > TIMEOUT) stop_with_error("timed out waiting for valid");
            end
        end
        @(negedge clk);     // hand back on a falling edge
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        lookup_pc = '0;
        errors = 0;
        mdl_valid = '0;
        lfsr_state = 32'ha8ce;

        stim[0] = make_op(op_b_jal, f3_beq, 0, 32'h100, 1'b1, pc_of(0) + 32'h100, '0, '0);
        stim[1] = make_op(op_b_jal, f3_beq, 1, 32'hffff_fff8, 1'b0, '0, '0, '0);
        stim[2] = make_op(op_b_jalr, f3_beq, 2, 32'h10, 1'b1, 32'h2011, 32'h2001, '0);
        stim[3] = make_op(op_b_jalr, f3_beq, 3, 32'h7, 1'b0, '0, lfsr_word(), '0);
        for (int n = 4; n < 28; n++) begin
            logic [31:0] imm;
            logic        bp;
            logic [31:0] bpa;
            int          k;
            imm = lfsr_bit() ? 32'h40 : 32'hffff_ffe0;
            bp  = lfsr_bit();
            bpa = lfsr_bit() ? pc_of(n) + imm : pc_of(n) + 32'd8;
            k   = (n - 4) % 4;
            if (k < 3) begin
                stim[n] = make_op(op_b_br, f3_list[(n-4)/4], n, imm, bp, bpa,
                                  edge_rs1[k], edge_rs2[k]);
            end else begin
                stim[n] = make_op(op_b_br, f3_list[(n-4)/4], n, imm, bp, bpa,
                                  lfsr_word(), lfsr_word());
            end
        end
        stim[28] = make_op(op_b_br, f3_beq, 28, 32'h40, 1'b1, pc_of(28) + 32'h44, 32'd5, 32'd5);
        stim[29] = make_op(op_b_br, f3_bne, 29, 32'h40, 1'b1, pc_of(29) + 32'h40, 32'd7, 32'd7);
        stim[30] = make_op(op_b_jal, f3_beq, 30, 32'h200, 1'b0, '0, '0, '0);
        stim[31] = make_op(op_b_jalr, f3_beq, 31, 32'h4, 1'b0, '0, 32'h5000, '0);
        stim[32] = make_op(op_b_jal, f3_beq, 32, 32'h10, 1'b0, '0, '0, '0);
        for (int n = 0; n < NTOTAL; n++) begin
            exp_res[n].tag  = stim[n].info.tag;
            exp_res[n].rd_v = (stim[n].info.opcode == op_b_br) ? '0 : stim[n].info.pc + 32'd4;
            exp_rdr[n]      = redirect_rule(stim[n]);
        end

        repeat (2) @(negedge clk);
        rst = 1'b0;
        if (valid !== 1'b0) report_mismatch("valid", 64'(valid), 64'h0);
        if (busy !== 1'b0) report_mismatch("busy", 64'(busy), 64'h0);
        if (issue_ready !== 1'b1) report_mismatch("issue_ready", 64'(issue_ready), 64'h1);
        if (redirect.pc_select !== 1'b0)
            report_mismatch("redirect.pc_select", 64'(redirect.pc_select), 64'h0);

        fork
            begin
                for (int i = 0; i < NMAIN; i++) push_op(stim[i]);
                issue_valid = 1'b0;
            end
            collect_results(0, NMAIN);
        join
        check_aliases(0, NMAIN);

        push_op(stim[NMAIN]);
        push_op(stim[NMAIN + 1]);
        issue_valid = 1'b0;
        flush = 1'b1;   // one op in the queue head register, one still queued
        @(negedge clk);
        flush = 1'b0;
        repeat (12) begin
            @(negedge clk);
            if (valid || redirect.pc_select) stop_with_error("a flushed operation completed");
        end
        if (busy) stop_with_error("functional unit still busy after the flush");
        if (issue_ready !== 1'b1) report_mismatch("issue_ready", 64'(issue_ready), 64'h1);
        check_btb(stim[NMAIN].info.pc);
        @(negedge clk);
        check_btb(stim[NMAIN + 1].info.pc);
        @(negedge clk);

        push_op(stim[NMAIN + 2]);
        issue_valid = 1'b0;
        collect_results(NMAIN + 2, 1);

        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_br_top

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/br_pkg.sv
hw/br_issue_queue.sv
hw/fu_br.sv
hw/btb.sv
hw/br_top.sv
bench/tb_br_top.sv

// File: hw/br_defs.svh
`ifndef BR_DEFS_SVH
`define BR_DEFS_SVH

// the BTB is indexed by pc bits 9 to 2
`define BTB_IDX_BITS 8
`define BTB_DEPTH    256

// number of entries in the branch issue queue
`define BR_Q_DEPTH   4

// reorder buffer tag that rides along with every operation
`define BR_TAG_BITS  6

`endif

// File: hw/br_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "br_defs.svh"

module br_issue_queue
    import br_pkg::*;
(
    input   logic       clk,
    input   logic       rst,
    input   logic       flush,
    input   logic       issue_valid,
    input   issue_t     issue,
    output  logic       issue_ready,
    output  logic       start,
    output  issue_t     head
);

    localparam int PTR_BITS = $clog2(`BR_Q_DEPTH);

    issue_t                 mem [`BR_Q_DEPTH];
    logic   [PTR_BITS-1:0]  wr_ptr;
    logic   [PTR_BITS-1:0]  rd_ptr;
    logic   [PTR_BITS:0]    count;
    logic                   push;
    logic                   pop;

    assign issue_ready = (count != (PTR_BITS+1)'(`BR_Q_DEPTH));
    assign push = issue_valid && issue_ready;
    assign pop  = (count != '0);    // the unit never stalls, so drain every cycle

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            start  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(`BR_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(`BR_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            start <= pop;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= issue;
        end
        if (pop) begin
            head <= mem[rd_ptr];    // only meaningful while start is high
        end
    end

endmodule : br_issue_queue

`default_nettype wire

// File: hw/br_pkg.sv
`default_nettype none

`include "br_defs.svh"

package br_pkg;

    typedef enum logic [1:0] {
        op_b_jal  = 2'd0,
        op_b_jalr = 2'd1,
        op_b_br   = 2'd2
    } br_op_e;

    // RV32I funct3 encodings of the conditional branches
    typedef enum logic [2:0] {
        f3_beq  = 3'b000,
        f3_bne  = 3'b001,
        f3_blt  = 3'b100,
        f3_bge  = 3'b101,
        f3_bltu = 3'b110,
        f3_bgeu = 3'b111
    } br_f3_e;

    typedef struct packed {
        br_op_e                     opcode;
        br_f3_e                     funct3;
        logic [`BR_TAG_BITS-1:0]    tag;
        logic [31:0]                pc;
        logic [31:0]                i_imm;
        logic [31:0]                b_imm;
        logic [31:0]                j_imm;
        logic                       bp;         // predicted taken
        logic [31:0]                bp_addr;    // predicted target
    } decode_info_t;

    typedef struct packed {
        decode_info_t   info;
        logic [31:0]    rs1_v;
        logic [31:0]    rs2_v;
    } issue_t;

    typedef struct packed {
        logic [`BR_TAG_BITS-1:0]    tag;
        logic [31:0]                rd_v;
    } result_t;

    typedef struct packed {
        logic           pc_select;
        logic [31:0]    pc_branch;
    } redirect_t;

    typedef struct packed {
        logic                           we;
        logic [`BTB_IDX_BITS-1:0]       idx;
        logic [29-`BTB_IDX_BITS:0]      pc_tag;     // pc bits above the index
        logic [31:0]                    target;
    } btb_wr_t;

endpackage : br_pkg

`default_nettype wire

// File: hw/br_top.sv
`timescale 1ns/1ps
`default_nettype none

module br_top
    import br_pkg::*;
(
    input   logic           clk,
    input   logic           rst,
    input   logic           flush,
    input   logic           issue_valid,
    input   issue_t         issue,
    output  logic           issue_ready,
    output  logic           valid,
    output  logic           busy,
    output  result_t        result,
    output  redirect_t      redirect,
    input   logic   [31:0]  lookup_pc,
    output  logic           pred_hit,
    output  logic   [31:0]  pred_target
);

    logic       start;
    issue_t     head;
    btb_wr_t    btb_wr;

    br_issue_queue br_issue_queue_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .start       (start),
        .head        (head)
    );

    fu_br fu_br_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .start    (start),
        .op       (head),
        .valid    (valid),
        .busy     (busy),
        .result   (result),
        .redirect (redirect),
        .btb_wr   (btb_wr)
    );

    btb btb_i (
        .clk         (clk),
        .rst         (rst),
        .btb_wr      (btb_wr),
        .lookup_pc   (lookup_pc),
        .pred_hit    (pred_hit),
        .pred_target (pred_target)
    );

endmodule : br_top

`default_nettype wire

// File: hw/btb.sv
`timescale 1ns/1ps
`default_nettype none

`include "br_defs.svh"

module btb
    import br_pkg::*;
(
    input   logic           clk,
    input   logic           rst,
    input   btb_wr_t        btb_wr,
    input   logic   [31:0]  lookup_pc,
    output  logic           pred_hit,
    output  logic   [31:0]  pred_target
);

    localparam int TAG_BITS = 30 - `BTB_IDX_BITS;

    logic   [`BTB_DEPTH-1:0]        entry_valid;
    logic   [TAG_BITS-1:0]          tag_mem [`BTB_DEPTH];
    logic   [31:0]                  target_mem [`BTB_DEPTH];

    logic   [`BTB_IDX_BITS-1:0]     lookup_idx;
    logic   [TAG_BITS-1:0]          lookup_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (btb_wr.we) begin
            entry_valid[btb_wr.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_wr.we) begin
            tag_mem[btb_wr.idx]    <= btb_wr.pc_tag;
            target_mem[btb_wr.idx] <= btb_wr.target;
        end
    end

    assign lookup_idx = lookup_pc[`BTB_IDX_BITS+1:2];
    assign lookup_tag = lookup_pc[31:`BTB_IDX_BITS+2];

    // an aliasing pc lands on the same entry but fails the tag check
    assign pred_hit    = entry_valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign pred_target = target_mem[lookup_idx];

endmodule : btb

`default_nettype wire

// File: hw/fu_br.sv
`timescale 1ns/1ps
`default_nettype none

`include "br_defs.svh"

module fu_br
    import br_pkg::*;
(
    input   logic       clk,
    input   logic       rst,
    input   logic       flush,
    input   logic       start,
    input   issue_t     op,
    output  logic       valid,
    output  logic       busy,
    output  result_t    result,
    output  redirect_t  redirect,
    output  btb_wr_t    btb_wr
);

    logic           s1_valid;
    issue_t         s1_op;

    logic           cmp_en;
    logic           s1_taken;
    logic   [31:0]  s1_target;
    logic   [31:0]  s1_rd_v;

    logic           s2_valid;
    decode_info_t   s2_info;
    logic           s2_taken;
    logic   [31:0]  s2_target;
    logic   [31:0]  s2_rd_v;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op     <= op;
        s2_info   <= s1_op.info;
        s2_taken  <= s1_taken;
        s2_target <= s1_target;
        s2_rd_v   <= s1_rd_v;
    end

    always_comb begin
        case (s1_op.info.funct3)
            f3_beq:  cmp_en = (s1_op.rs1_v == s1_op.rs2_v);
            f3_bne:  cmp_en = (s1_op.rs1_v != s1_op.rs2_v);
            f3_blt:  cmp_en = (signed'(s1_op.rs1_v) <  signed'(s1_op.rs2_v));
            f3_bge:  cmp_en = (signed'(s1_op.rs1_v) >= signed'(s1_op.rs2_v));
            f3_bltu: cmp_en = (s1_op.rs1_v <  s1_op.rs2_v);
            f3_bgeu: cmp_en = (s1_op.rs1_v >= s1_op.rs2_v);
            default: cmp_en = 1'b0;
        endcase
    end

    always_comb begin
        s1_rd_v   = '0;
        s1_taken  = 1'b0;
        s1_target = '0;
        case (s1_op.info.opcode)
            op_b_jal: begin
                s1_rd_v   = s1_op.info.pc + 32'd4;
                s1_taken  = 1'b1;
                s1_target = s1_op.info.pc + s1_op.info.j_imm;
            end
            op_b_jalr: begin
                s1_rd_v   = s1_op.info.pc + 32'd4;
                s1_taken  = 1'b1;
                s1_target = (s1_op.rs1_v + s1_op.info.i_imm) & ~32'd1;  // bit 0 is dropped
            end
            op_b_br: begin
                s1_taken  = cmp_en;
                s1_target = s1_op.info.pc + s1_op.info.b_imm;
            end
            default: begin
                s1_taken = 1'b0;    // unknown opcode resolves as not taken
            end
        endcase
    end

    assign valid = s2_valid;
    assign busy  = s1_valid | s2_valid;

    always_comb begin
        result.tag  = s2_info.tag;
        result.rd_v = s2_rd_v;
    end

    always_comb begin
        redirect = '0;
        if (s2_valid) begin
            if (s2_info.bp && s2_taken && (s2_info.bp_addr == s2_target)) begin
                redirect.pc_select = 1'b0;  // prediction was right
            end else if (s2_info.bp && !s2_taken) begin
                redirect.pc_select = 1'b1;
                redirect.pc_branch = s2_info.pc + 32'd4;
            end else if (s2_taken) begin
                redirect.pc_select = 1'b1;
                redirect.pc_branch = s2_target;
            end
        end
    end

    // every taken outcome trains the BTB
    always_comb begin
        btb_wr.we     = s2_valid && s2_taken;
        btb_wr.idx    = s2_info.pc[`BTB_IDX_BITS+1:2];
        btb_wr.pc_tag = s2_info.pc[31:`BTB_IDX_BITS+2];
        btb_wr.target = s2_target;
    end

endmodule : fu_br

`default_nettype wire
